/* hw/dram_pkg.sv */
package dram_pkg;

    // ------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------
    localparam int addr_w   = 32;
    localparam int data_w   = 32;
    localparam int id_w     = 8;
    localparam int strb_w   = 4;

    // ------------------------------------------------------------
    // DRAM address split
    // ------------------------------------------------------------
    // Row from address bits 20..12, column from bits 11..2
    localparam int row_w    = 9;
    localparam int row_lsb  = 12;
    localparam int col_w    = 10;
    localparam int col_lsb  = 2;
    localparam int dram_a_w = 11;

    localparam logic [1:0] resp_okay = 2'b00;

    // One posted write waiting for the DRAM
    typedef struct packed {
        logic [row_w-1:0]  row;
        logic [col_w-1:0]  col;
        logic [strb_w-1:0] strb;
        logic [data_w-1:0] data;
    } wr_entry_t;

    // Open read request
    typedef struct packed {
        logic [row_w-1:0] row;
        logic [col_w-1:0] col;
    } rd_req_t;

    // Complete DRAM command bus, all strobes active low
    typedef struct packed {
        logic                csn;
        logic                rasn;
        logic                casn;
        logic [strb_w-1:0]   wen;
        logic [dram_a_w-1:0] a;
        logic [data_w-1:0]   d;
    } dram_pins_t;

endpackage

/* hw/axi_slave_port.sv */
`timescale 1ns/1ps

module axi_slave_port (
    input  logic                          clk,
    input  logic                          rstn,
    // AR and R
    input  logic [dram_pkg::id_w-1:0]     arid,
    input  logic [dram_pkg::addr_w-1:0]   araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [dram_pkg::id_w-1:0]     rid,
    output logic [dram_pkg::data_w-1:0]   rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,
    // AW, W and B
    input  logic [dram_pkg::id_w-1:0]     awid,
    input  logic [dram_pkg::addr_w-1:0]   awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [dram_pkg::data_w-1:0]   wdata,
    input  logic [dram_pkg::strb_w-1:0]   wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [dram_pkg::id_w-1:0]     bid,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    // Write buffer side
    input  logic                          wr_full,
    output logic                          wr_push,
    output dram_pkg::wr_entry_t           wr_entry,
    input  logic                          wr_pending,
    // Scheduler side
    output logic                          rd_req_valid,
    output dram_pkg::rd_req_t             rd_req,
    input  logic                          rd_issue,
    input  logic [dram_pkg::data_w-1:0]   dram_q,
    input  logic                          dram_valid
);

    typedef enum logic [2:0] {
        s_idle,
        s_wr_data,
        s_wr_resp,
        s_rd_wait,
        s_rd_resp
    } state_t;

    state_t                        state;
    state_t                        state_nx;
    logic                          aw_hs;
    logic                          w_hs;
    logic                          b_hs;
    logic                          ar_hs;
    logic                          r_hs;
    logic                          rd_sent;
    logic [dram_pkg::addr_w-1:0]   addr_sel;
    logic [dram_pkg::id_w-1:0]     id_q;
    logic [dram_pkg::row_w-1:0]    row_q;
    logic [dram_pkg::col_w-1:0]    col_q;
    logic [dram_pkg::data_w-1:0]   rdata_q;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign b_hs  = bvalid && bready;
    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    // Writes take the idle slot first, reads only behind an empty buffer
    assign awready = (state == s_idle);
    assign arready = (state == s_idle) && !wr_pending && !awvalid;
    assign wready  = (state == s_wr_data) && !wr_full;
    assign bvalid  = (state == s_wr_resp);
    assign rvalid  = (state == s_rd_resp);

    assign bid   = id_q;
    assign rid   = id_q;
    assign bresp = dram_pkg::resp_okay;
    assign rresp = dram_pkg::resp_okay;
    assign rdata = rdata_q;

    assign wr_push  = w_hs;
    assign wr_entry = '{row: row_q, col: col_q, strb: wstrb, data: wdata};

    // Request stays up until the scheduler drives the read column
    assign rd_req_valid = (state == s_rd_wait) && !rd_sent;
    assign rd_req       = '{row: row_q, col: col_q};

    assign addr_sel = ar_hs ? araddr : awaddr;

    always_comb begin
        state_nx = state;
        case (state)
            s_idle: begin
                if (aw_hs) begin
                    state_nx = s_wr_data;
                end else if (ar_hs) begin
                    state_nx = s_rd_wait;
                end
            end
            s_wr_data: if (w_hs) state_nx = s_wr_resp;
            s_wr_resp: if (b_hs) state_nx = s_idle;
            s_rd_wait: if (dram_valid && rd_sent) state_nx = s_rd_resp;
            s_rd_resp: if (r_hs) state_nx = s_idle;
            default:   state_nx = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= s_idle;
            rd_sent <= 1'b0;
        end else begin
            state <= state_nx;
            if (ar_hs) begin
                rd_sent <= 1'b0;
            end else if (rd_issue) begin
                rd_sent <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Address, ID and read data holding
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (aw_hs || ar_hs) begin
            id_q  <= ar_hs ? arid : awid;
            row_q <= addr_sel[dram_pkg::row_lsb +: dram_pkg::row_w];
            col_q <= addr_sel[dram_pkg::col_lsb +: dram_pkg::col_w];
        end
        if ((state == s_rd_wait) && dram_valid) begin
            rdata_q <= dram_q;
        end
    end

    // R beat holds until the master takes it
    a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
        rvalid && !rready |=> rvalid && $stable(rdata));

    // Scheduler only answers an open read request
    a_issue_requested: assert property (@(posedge clk) disable iff (!rstn)
        rd_issue |-> rd_req_valid);

endmodule

/* hw/write_buffer.sv */
`timescale 1ns/1ps

module write_buffer #(
    parameter int depth = 2
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                wr_push,
    input  dram_pkg::wr_entry_t wr_entry,
    input  logic                wr_pop,
    output dram_pkg::wr_entry_t wr_head,
    output logic                wr_pending,
    output logic                wr_full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    dram_pkg::wr_entry_t mem [depth];
    logic [ptr_w-1:0]    wr_ptr;
    logic [ptr_w-1:0]    rd_ptr;
    logic [cnt_w-1:0]    count;

    assign wr_head    = mem[rd_ptr];
    assign wr_pending = (count != '0);
    assign wr_full    = (count == cnt_w'(depth));

    // Entry storage
    always_ff @(posedge clk) begin
        if (wr_push) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    // Pointers wrap at depth, which need not be a power of two
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (wr_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_push, wr_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        wr_full |-> !wr_push);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rstn)
        !wr_pending |-> !wr_pop);

endmodule

/* hw/dram_cmd_sched.sv */
`timescale 1ns/1ps

module dram_cmd_sched #(
    parameter int cas_wait = 4,
    parameter int ras_wait = 4
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 rd_req_valid,
    input  dram_pkg::rd_req_t    rd_req,
    output logic                 rd_issue,
    input  dram_pkg::wr_entry_t  wr_head,
    input  logic                 wr_pending,
    output logic                 wr_pop,
    output dram_pkg::dram_pins_t dram
);

    localparam int cas_cnt_w = (cas_wait > 0) ? $clog2(cas_wait + 1) : 1;
    localparam int ras_cnt_w = (ras_wait > 0) ? $clog2(ras_wait + 1) : 1;
    localparam int row_pad   = dram_pkg::dram_a_w - dram_pkg::row_w;
    localparam int col_pad   = dram_pkg::dram_a_w - dram_pkg::col_w;

    typedef enum logic [1:0] {
        st_act,
        st_read,
        st_write,
        st_pre
    } state_t;

    state_t                     state;
    state_t                     state_nx;
    logic [cas_cnt_w-1:0]       phase;
    logic [cas_cnt_w-1:0]       cas_cool;
    logic [ras_cnt_w-1:0]       ras_cool;
    logic [dram_pkg::row_w-1:0] open_row;
    logic [dram_pkg::row_w-1:0] target_row;
    logic                       phase_last;
    logic                       any_req;
    logic                       wr_hit;
    logic                       rd_hit;
    logic                       col_ready;
    logic                       act_ready;
    logic                       act_issue;
    logic                       pre_issue;

    // ------------------------------------------------------------
    // Arbitration
    // ------------------------------------------------------------
    assign any_req    = wr_pending || rd_req_valid;
    assign target_row = wr_pending ? wr_head.row : rd_req.row;
    assign wr_hit     = (wr_head.row == open_row);
    assign rd_hit     = (rd_req.row == open_row);
    assign col_ready  = (cas_cool == '0);
    assign act_ready  = (ras_cool == '0);
    assign phase_last = (phase == cas_cnt_w'(cas_wait));

    // A pending write always wins the column slot
    assign wr_pop    = (state == st_write) && wr_pending && wr_hit && col_ready;
    assign rd_issue  = (state == st_read) && !wr_pending && rd_req_valid && rd_hit
                       && col_ready;
    assign act_issue = (state == st_act) && (phase == '0) && any_req && act_ready;
    assign pre_issue = (state == st_pre) && (phase == '0);

    always_comb begin
        state_nx = state;
        case (state)
            st_act: begin
                if (phase_last) begin
                    state_nx = wr_pending ? st_write : st_read;
                end
            end
            st_read, st_write: begin
                // Leave the row only once the last column has settled
                if (col_ready) begin
                    if (wr_pending) begin
                        state_nx = wr_hit ? st_write : st_pre;
                    end else if (rd_req_valid) begin
                        state_nx = rd_hit ? st_read : st_pre;
                    end
                end
            end
            st_pre:  if (phase_last) state_nx = st_act;
            default: state_nx = st_act;
        endcase
    end

    // ------------------------------------------------------------
    // State, phase counter, open row and cooldowns
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= st_act;
            phase    <= '0;
            open_row <= '0;
        end else begin
            state <= state_nx;
            if (state == st_act || state == st_pre) begin
                // Phase 0 waits in activate until a request and tRP allow it
                if (phase_last) begin
                    phase <= '0;
                end else if (phase != '0 || act_issue || pre_issue) begin
                    phase <= phase + 1'b1;
                end
            end else begin
                phase <= '0;
            end
            if (act_issue) begin
                open_row <= target_row;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cas_cool <= '0;
            ras_cool <= '0;
        end else begin
            if (rd_issue || wr_pop) begin
                cas_cool <= cas_cnt_w'(cas_wait);
            end else if (!col_ready) begin
                cas_cool <= cas_cool - 1'b1;
            end
            if (pre_issue) begin
                ras_cool <= ras_cnt_w'(ras_wait);
            end else if (!act_ready) begin
                ras_cool <= ras_cool - 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Pin encoding
    // ------------------------------------------------------------
    always_comb begin
        dram.csn  = 1'b0;
        dram.rasn = 1'b1;
        dram.casn = 1'b1;
        dram.wen  = '1;
        dram.a    = {{row_pad{1'b0}}, open_row};
        dram.d    = wr_head.data;
        if (act_issue) begin
            dram.rasn = 1'b0;
            dram.a    = {{row_pad{1'b0}}, target_row};
        end else if (pre_issue) begin
            dram.rasn = 1'b0;
            dram.wen  = '0;
        end else if (wr_pop) begin
            dram.casn = 1'b0;
            dram.wen  = ~wr_head.strb;
            dram.a    = {{col_pad{1'b0}}, wr_head.col};
        end else if (rd_issue) begin
            dram.casn = 1'b0;
            dram.a    = {{col_pad{1'b0}}, rd_req.col};
        end
    end

    // No column command for cas_wait cycles after the last one
    a_cas_spacing: assert property (@(posedge clk) disable iff (!rstn)
        !dram.casn |=> dram.casn [*cas_wait]);

endmodule

/* hw/dram_ctrl_top.sv */
`timescale 1ns/1ps

module dram_ctrl_top #(
    parameter int cas_wait   = 4,
    parameter int ras_wait   = 4,
    parameter int wbuf_depth = 2
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [dram_pkg::id_w-1:0]     arid,
    input  logic [dram_pkg::addr_w-1:0]   araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [dram_pkg::id_w-1:0]     rid,
    output logic [dram_pkg::data_w-1:0]   rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,
    input  logic [dram_pkg::id_w-1:0]     awid,
    input  logic [dram_pkg::addr_w-1:0]   awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [dram_pkg::data_w-1:0]   wdata,
    input  logic [dram_pkg::strb_w-1:0]   wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [dram_pkg::id_w-1:0]     bid,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [dram_pkg::data_w-1:0]   dram_q,
    input  logic                          dram_valid,
    output dram_pkg::dram_pins_t          dram
);

    logic                wr_full;
    logic                wr_push;
    logic                wr_pending;
    logic                wr_pop;
    logic                rd_req_valid;
    logic                rd_issue;
    dram_pkg::wr_entry_t wr_entry;
    dram_pkg::wr_entry_t wr_head;
    dram_pkg::rd_req_t   rd_req;

    // ------------------------------------------------------------
    // AXI front end
    // ------------------------------------------------------------
    axi_slave_port u_slave (
        .clk(clk), .rstn(rstn),
        .arid(arid), .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rid(rid), .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .awid(awid), .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bid(bid), .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .wr_full(wr_full), .wr_push(wr_push), .wr_entry(wr_entry),
        .wr_pending(wr_pending),
        .rd_req_valid(rd_req_valid), .rd_req(rd_req), .rd_issue(rd_issue),
        .dram_q(dram_q), .dram_valid(dram_valid)
    );

    // Posted writes
    write_buffer #(
        .depth(wbuf_depth)
    ) u_wbuf (
        .clk(clk), .rstn(rstn),
        .wr_push(wr_push), .wr_entry(wr_entry), .wr_pop(wr_pop),
        .wr_head(wr_head), .wr_pending(wr_pending), .wr_full(wr_full)
    );

    dram_cmd_sched #(
        .cas_wait(cas_wait),
        .ras_wait(ras_wait)
    ) u_sched (
        .clk(clk), .rstn(rstn),
        .rd_req_valid(rd_req_valid), .rd_req(rd_req), .rd_issue(rd_issue),
        .wr_head(wr_head), .wr_pending(wr_pending), .wr_pop(wr_pop),
        .dram(dram)
    );

endmodule

/* verification/dram_model.sv */
`timescale 1ns/1ps

module dram_model #(
    parameter int lat = 2
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  dram_pkg::dram_pins_t        dram,
    output logic [dram_pkg::data_w-1:0] dram_q,
    output logic                        dram_valid,
    output int                          illegal_cnt
);

    logic [dram_pkg::data_w-1:0] mem [int unsigned];
    logic                        row_open;
    logic [dram_pkg::row_w-1:0]  row_q;
    logic                        vld_pipe [lat];
    logic [dram_pkg::data_w-1:0] dat_pipe [lat];
    logic                        is_act;
    logic                        is_pre;
    logic                        is_rd;
    logic                        is_wr;
    logic                        is_bad;

    // ------------------------------------------------------------
    // Command decode, strobes active low
    // ------------------------------------------------------------
    assign is_act = !dram.csn && !dram.rasn && dram.casn && (dram.wen == '1);
    assign is_pre = !dram.csn && !dram.rasn && dram.casn && (dram.wen == '0);
    assign is_rd  = !dram.csn && dram.rasn && !dram.casn && (dram.wen == '1);
    assign is_wr  = !dram.csn && dram.rasn && !dram.casn && (dram.wen != '1);
    assign is_bad = !dram.csn && !dram.rasn && !is_act && !is_pre;

    assign dram_q     = dat_pipe[lat-1];
    assign dram_valid = vld_pipe[lat-1];

    always @(posedge clk) begin : decode
        int unsigned                 key;
        logic [dram_pkg::data_w-1:0] word;
        int                          i;
        key  = {row_q, dram.a[dram_pkg::col_w-1:0]};
        word = mem.exists(key) ? mem[key] : '0;
        if (!rstn) begin
            row_open = 1'b0;
            row_q    = '0;
            illegal_cnt <= 0;
            for (i = 0; i < lat; i++) begin
                vld_pipe[i] <= 1'b0;
                dat_pipe[i] <= '0;
            end
        end else begin
            // Read data comes out lat cycles after the column command
            for (i = lat - 1; i > 0; i--) begin
                vld_pipe[i] <= vld_pipe[i-1];
                dat_pipe[i] <= dat_pipe[i-1];
            end
            vld_pipe[0] <= is_rd && row_open;
            dat_pipe[0] <= word;
            if (is_act) begin
                if (row_open) begin
                    illegal_cnt <= illegal_cnt + 1;
                    $display("DRAM model at %0t: activate while row %0d is open", $time, row_q);
                end
                row_open = 1'b1;
                row_q    = dram.a[dram_pkg::row_w-1:0];
            end else if (is_pre) begin
                row_open = 1'b0;
            end else if (is_rd || is_wr) begin
                if (!row_open) begin
                    illegal_cnt <= illegal_cnt + 1;
                    $display("DRAM model at %0t: column command with no open row", $time);
                end else if (is_wr) begin
                    for (i = 0; i < dram_pkg::strb_w; i++) begin
                        if (!dram.wen[i]) word[i*8 +: 8] = dram.d[i*8 +: 8];
                    end
                    mem[key] = word;
                end
            end else if (is_bad) begin
                illegal_cnt <= illegal_cnt + 1;
                $display("DRAM model at %0t: unknown command on the pins", $time);
            end
        end
    end

endmodule

/* verification/tb_dram_ctrl.sv */
`timescale 1ns/1ps

module tb_dram_ctrl;

    localparam int cas_wait   = 4;
    localparam int ras_wait   = 4;
    localparam int wbuf_depth = 2;
    localparam int model_lat  = 2;
    localparam int timeout    = 400;

    logic                          clk;
    logic                          rstn;
    logic [dram_pkg::id_w-1:0]     arid;
    logic [dram_pkg::addr_w-1:0]   araddr;
    logic                          arvalid;
    logic                          arready;
    logic [dram_pkg::id_w-1:0]     rid;
    logic [dram_pkg::data_w-1:0]   rdata;
    logic [1:0]                    rresp;
    logic                          rvalid;
    logic                          rready;
    logic [dram_pkg::id_w-1:0]     awid;
    logic [dram_pkg::addr_w-1:0]   awaddr;
    logic                          awvalid;
    logic                          awready;
    logic [dram_pkg::data_w-1:0]   wdata;
    logic [dram_pkg::strb_w-1:0]   wstrb;
    logic                          wvalid;
    logic                          wready;
    logic [dram_pkg::id_w-1:0]     bid;
    logic [1:0]                    bresp;
    logic                          bvalid;
    logic                          bready;
    logic [dram_pkg::data_w-1:0]   dram_q;
    logic                          dram_valid;
    dram_pkg::dram_pins_t          dram;
    int                            illegal_cnt;

    // Scoreboard, keyed by byte address
    logic [dram_pkg::data_w-1:0]   sb_mem [int unsigned];

    dram_ctrl_top #(
        .cas_wait(cas_wait), .ras_wait(ras_wait), .wbuf_depth(wbuf_depth)
    ) u_dut (
        .clk(clk), .rstn(rstn),
        .arid(arid), .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rid(rid), .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .awid(awid), .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bid(bid), .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .dram_q(dram_q), .dram_valid(dram_valid), .dram(dram)
    );

    dram_model #(
        .lat(model_lat)
    ) u_model (
        .clk(clk), .rstn(rstn), .dram(dram),
        .dram_q(dram_q), .dram_valid(dram_valid), .illegal_cnt(illegal_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    // Row in bits 20..12, column in bits 11..2
    function automatic logic [31:0] make_addr(input int row, input int col);
        return (row << 12) | (col << 2);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        int          b;
        res = old_word;
        for (b = 0; b < 4; b++) begin
            if (strb[b]) res[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return sb_mem.exists(addr) ? sb_mem[addr] : 32'h0;
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "check failed");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t ns: no %s within %0d cycles", $time, what, timeout);
        $display("ERRORS FOUND");
        $fatal(1, "handshake never completed");
    endtask

    // ------------------------------------------------------------
    // AXI transactions
    // ------------------------------------------------------------
    // Outputs are sampled on the falling edge, transfers complete on the next rising edge
    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [7:0] id, input int stall);
        int cnt;
        int hold;
        @(posedge clk);
        awid    <= id;
        awaddr  <= addr;
        awvalid <= 1'b1;
        cnt = 0;
        @(negedge clk);
        while (!awready) begin
            cnt++;
            if (cnt > timeout) stop_on_timeout("AW handshake");
            @(negedge clk);
        end
        @(posedge clk);
        awvalid <= 1'b0;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        cnt = 0;
        @(negedge clk);
        while (!wready) begin
            cnt++;
            if (cnt > timeout) stop_on_timeout("W handshake");
            @(negedge clk);
        end
        @(posedge clk);
        wvalid <= 1'b0;
        sb_mem[addr] = merge_bytes(expected_word(addr), data, strb);
        cnt = 0;
        @(negedge clk);
        while (!bvalid) begin
            cnt++;
            if (cnt > timeout) stop_on_timeout("BVALID");
            @(negedge clk);
        end
        hold = (stall > 0) ? ($urandom % (stall + 1)) : 0;
        repeat (hold) begin
            @(negedge clk);
            check_equal(bvalid, 1'b1, "BVALID held while BREADY low");
        end
        @(posedge clk);
        bready <= 1'b1;
        @(negedge clk);
        check_equal(bvalid, 1'b1, "BVALID at B handshake");
        check_equal(bid, id, "BID");
        check_equal(bresp, 2'b00, "BRESP");
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, input logic [7:0] id, input int stall,
                            output logic [31:0] got);
        int          cnt;
        int          hold;
        logic [31:0] held;
        @(posedge clk);
        arid    <= id;
        araddr  <= addr;
        arvalid <= 1'b1;
        cnt = 0;
        @(negedge clk);
        while (!arready) begin
            cnt++;
            if (cnt > timeout) stop_on_timeout("AR handshake");
            @(negedge clk);
        end
        @(posedge clk);
        arvalid <= 1'b0;
        cnt = 0;
        @(negedge clk);
        while (!rvalid) begin
            cnt++;
            if (cnt > timeout) stop_on_timeout("RVALID");
            @(negedge clk);
        end
        held = rdata;
        hold = (stall > 0) ? ($urandom % (stall + 1)) : 0;
        repeat (hold) begin
            @(negedge clk);
            check_equal(rvalid, 1'b1, "RVALID held while RREADY low");
            check_equal(rdata, held, "RDATA stable while RREADY low");
        end
        @(posedge clk);
        rready <= 1'b1;
        @(negedge clk);
        check_equal(rvalid, 1'b1, "RVALID at R handshake");
        check_equal(rdata, expected_word(addr), "RDATA");
        check_equal(rid, id, "RID");
        check_equal(rresp, 2'b00, "RRESP");
        got = rdata;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic reset_values();
        @(negedge clk);
        check_equal(awready, 1'b1, "AWREADY after reset");
        check_equal(arready, 1'b1, "ARREADY after reset");
        check_equal(rvalid, 1'b0, "RVALID after reset");
        check_equal(bvalid, 1'b0, "BVALID after reset");
        check_equal(wready, 1'b0, "WREADY after reset");
        check_equal(dram.rasn, 1'b1, "rasn after reset");
        check_equal(dram.casn, 1'b1, "casn after reset");
        check_equal(dram.wen, 4'hf, "wen after reset");
        check_equal(dram.csn, 1'b0, "csn after reset");
    endtask

    task automatic write_then_read();
        logic [31:0] got;
        axi_write(make_addr(3, 17), 32'hcafe_f00d, 4'hf, 8'h21, 0);
        axi_read(make_addr(3, 17), 8'h42, 0, got);
        axi_write(make_addr(3, 18), 32'h1234_5678, 4'hf, 8'h05, 0);
        axi_read(make_addr(3, 18), 8'h06, 0, got);
        check_equal(got, 32'h1234_5678, "read after write");
    endtask

    task automatic partial_strobe_merge();
        logic [31:0] got;
        axi_write(make_addr(4, 100), 32'h1122_3344, 4'hf, 8'h10, 0);
        axi_write(make_addr(4, 100), 32'haabb_ccdd, 4'b0101, 8'h11, 0);
        axi_read(make_addr(4, 100), 8'h12, 0, got);
        check_equal(got, 32'h11bb_33dd, "byte-merged word");
    endtask

    // Alternating rows force precharge and activate between accesses
    task automatic row_switching();
        logic [31:0] got;
        axi_write(make_addr(10, 4), 32'h0a0a_0004, 4'hf, 8'h01, 0);
        axi_read(make_addr(10, 4), 8'h02, 0, got);
        axi_write(make_addr(200, 4), 32'hc8c8_0004, 4'hf, 8'h03, 0);
        axi_read(make_addr(10, 4), 8'h04, 0, got);
        axi_read(make_addr(200, 4), 8'h05, 0, got);
        axi_write(make_addr(10, 9), 32'h0a0a_0009, 4'hf, 8'h06, 0);
        axi_write(make_addr(200, 9), 32'hc8c8_0009, 4'b0011, 8'h07, 0);
        axi_read(make_addr(10, 9), 8'h08, 0, got);
        axi_read(make_addr(200, 9), 8'h09, 0, got);
        check_equal(illegal_cnt, 0, "illegal DRAM commands");
    endtask

    task automatic backpressure();
        logic [31:0] got;
        logic [31:0] addr;
        int          i;
        for (i = 0; i < 6; i++) begin
            addr = make_addr(20 + (i % 2), i);
            axi_write(addr, $urandom, 4'hf, 8'(i), 6);
            axi_read(addr, 8'(8'h80 + i), 6, got);
        end
    endtask

    task automatic random_traffic();
        int          rows [3];
        int          cols [4];
        int          r;
        int          c;
        logic [31:0] got;
        rows = '{5, 6, 311};
        cols = '{0, 1, 2, 1023};
        for (r = 0; r < 3; r++) begin
            for (c = 0; c < 4; c++) begin
                axi_write(make_addr(rows[r], cols[c]), $urandom, 4'hf, 8'h00, 0);
            end
        end
        repeat (40) begin
            r = $urandom % 3;
            c = $urandom % 4;
            if ($urandom % 2) begin
                axi_write(make_addr(rows[r], cols[c]), $urandom, 4'(($urandom % 15) + 1),
                          8'($urandom), 2);
            end else begin
                axi_read(make_addr(rows[r], cols[c]), 8'($urandom), 2, got);
            end
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        void'($urandom(83));
        rstn    <= 1'b0;
        arid    <= '0;
        araddr  <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        awid    <= '0;
        awaddr  <= '0;
        awvalid <= 1'b0;
        wdata   <= '0;
        wstrb   <= '0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        reset_values();
        write_then_read();
        partial_strobe_merge();
        row_switching();
        backpressure();
        random_traffic();
        check_equal(illegal_cnt, 0, "illegal DRAM commands over the run");
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* flist.f */
hw/dram_pkg.sv
hw/axi_slave_port.sv
hw/write_buffer.sv
hw/dram_cmd_sched.sv
hw/dram_ctrl_top.sv
verification/dram_model.sv
verification/tb_dram_ctrl.sv
